// File: verilog/frame_store_pkg.sv
package frame_store_pkg;

    // frame marks sit in the top byte of a beat
    localparam int MARK_WIDTH = 8;
    localparam logic [MARK_WIDTH-1:0] HEADER_MARK = 8'hAA;
    localparam logic [MARK_WIDTH-1:0] FOOTER_MARK = 8'h55;

    // command channel field widths
    localparam int TAG_WIDTH = 4;
    localparam int SLOT_LEN_WIDTH = 8;

    // the mover runs one machine per direction, each uses idle plus its own state
    typedef enum logic [1:0] {
        MOVER_IDLE,
        MOVER_WRITING,
        MOVER_READING
    } mover_state_e;

    // egress drops slot filler while hunting
    typedef enum logic {
        EGRESS_HUNT,
        EGRESS_PASS
    } egress_state_e;

endpackage

// File: verilog/dm_cmd_if.sv
interface dm_cmd_if #(
    parameter int ADDR_WIDTH = 6
);

    logic                                       cmd_valid;
    logic                                       cmd_ready;
    // word address of the slot
    logic [ADDR_WIDTH-1:0]                      cmd_addr;
    // slot length in beats
    logic [frame_store_pkg::SLOT_LEN_WIDTH-1:0] cmd_len;
    logic [frame_store_pkg::TAG_WIDTH-1:0]      cmd_tag;
    // one-cycle pulse when the transfer is done
    logic                                       cmplt;

    modport mmu (
        output cmd_valid,
        output cmd_addr,
        output cmd_len,
        output cmd_tag,
        input  cmd_ready,
        input  cmplt
    );

    modport mover (
        input  cmd_valid,
        input  cmd_addr,
        input  cmd_len,
        input  cmd_tag,
        output cmd_ready,
        output cmplt
    );

endinterface

// File: verilog/frame_buffer_mmu.sv
module frame_buffer_mmu #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6
) (
    input  logic                                       ACLK,
    input  logic                                       ARESET,
    input  logic                                       set_config,
    input  logic [frame_store_pkg::SLOT_LEN_WIDTH-1:0] max_frame_beats,

    input  logic [DATA_WIDTH-1:0]                      s_tdata,
    input  logic                                       s_tvalid,
    input  logic                                       s_tlast,
    output logic                                       s_tready,

    output logic [DATA_WIDTH-1:0]                      wr_tdata,
    output logic                                       wr_tvalid,
    output logic                                       wr_tlast,
    input  logic                                       wr_tready,

    dm_cmd_if.mmu                                      wr_cmd,
    dm_cmd_if.mmu                                      rd_cmd
);

    localparam int SLW = frame_store_pkg::SLOT_LEN_WIDTH;
    localparam int MEM_WORDS = 2 ** ADDR_WIDTH;
    // wide enough for address plus two slot lengths without overflow
    localparam int SUM_WIDTH = ((ADDR_WIDTH > SLW) ? ADDR_WIDTH : SLW) + 2;
    localparam logic [SLW-1:0] DEFAULT_SLOT_LEN = 16;

    logic [SLW-1:0]                        slot_len;
    // pointers carry a wrap bit above the word address
    logic [ADDR_WIDTH:0]                   wr_ptr;
    logic [ADDR_WIDTH:0]                   rd_ptr;
    logic [ADDR_WIDTH:0]                   wr_ptr_next;
    logic [ADDR_WIDTH:0]                   rd_ptr_next;
    logic                                  full;
    logic                                  almost_full;
    logic                                  empty;

    logic                                  wr_cmd_valid;
    logic                                  wr_busy;
    logic                                  wr_granted;
    logic [frame_store_pkg::TAG_WIDTH-1:0] wr_tag;
    logic                                  rd_cmd_valid;
    logic                                  rd_busy;
    logic [frame_store_pkg::TAG_WIDTH-1:0] rd_tag;
    logic                                  ingress_open;
    logic                                  wr_last_beat;

    // next slot start, back to zero when another whole slot would not fit
    function automatic logic [ADDR_WIDTH:0] step_ptr(
        input logic [ADDR_WIDTH:0] ptr,
        input logic [SLW-1:0]      len
    );
        logic [SUM_WIDTH-1:0] next_addr;
        next_addr = SUM_WIDTH'(ptr[ADDR_WIDTH-1:0]) + SUM_WIDTH'(len);
        if (next_addr + SUM_WIDTH'(len) > SUM_WIDTH'(MEM_WORDS)) begin
            return {~ptr[ADDR_WIDTH], {ADDR_WIDTH{1'b0}}};
        end
        return {ptr[ADDR_WIDTH], next_addr[ADDR_WIDTH-1:0]};
    endfunction

    assign wr_ptr_next = step_ptr(wr_ptr, slot_len);
    assign rd_ptr_next = step_ptr(rd_ptr, slot_len);

    assign empty       = (wr_ptr == rd_ptr);
    assign full        = (wr_ptr == {~rd_ptr[ADDR_WIDTH], rd_ptr[ADDR_WIDTH-1:0]});
    assign almost_full = (wr_ptr_next == {~rd_ptr[ADDR_WIDTH], rd_ptr[ADDR_WIDTH-1:0]});

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            slot_len <= DEFAULT_SLOT_LEN;
        end else if (set_config) begin
            slot_len <= max_frame_beats;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_cmd.cmplt) begin
                wr_ptr <= wr_ptr_next;
            end
            if (rd_cmd.cmplt) begin
                rd_ptr <= rd_ptr_next;
            end
        end
    end

    // write command goes out ahead of the frame so the mover has its address first
    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            wr_cmd_valid <= 1'b0;
            wr_busy      <= 1'b0;
            wr_granted   <= 1'b0;
            wr_tag       <= '0;
        end else begin
            if (!wr_busy && !full && !almost_full) begin
                wr_cmd_valid <= 1'b1;
                wr_busy      <= 1'b1;
            end else if (wr_cmd_valid && wr_cmd.cmd_ready) begin
                wr_cmd_valid <= 1'b0;
            end
            if (wr_cmd_valid && wr_cmd.cmd_ready) begin
                wr_granted <= 1'b1;
            end else if (wr_last_beat) begin
                wr_granted <= 1'b0;
            end
            if (wr_cmd.cmplt) begin
                wr_busy <= 1'b0;
                wr_tag  <= wr_tag + 1'b1;
            end
        end
    end

    // one read in flight at a time
    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            rd_cmd_valid <= 1'b0;
            rd_busy      <= 1'b0;
            rd_tag       <= '0;
        end else begin
            if (!rd_busy && !empty) begin
                rd_cmd_valid <= 1'b1;
                rd_busy      <= 1'b1;
            end else if (rd_cmd_valid && rd_cmd.cmd_ready) begin
                rd_cmd_valid <= 1'b0;
                rd_tag       <= rd_tag + 1'b1;
            end
            if (rd_cmd.cmplt) begin
                rd_busy <= 1'b0;
            end
        end
    end

    assign wr_cmd.cmd_valid = wr_cmd_valid;
    assign wr_cmd.cmd_addr  = wr_ptr[ADDR_WIDTH-1:0];
    assign wr_cmd.cmd_len   = slot_len;
    assign wr_cmd.cmd_tag   = wr_tag;

    assign rd_cmd.cmd_valid = rd_cmd_valid;
    assign rd_cmd.cmd_addr  = rd_ptr[ADDR_WIDTH-1:0];
    assign rd_cmd.cmd_len   = slot_len;
    assign rd_cmd.cmd_tag   = rd_tag;

    // ingress passes straight through once a slot is granted
    assign ingress_open = wr_granted & ~full & ~almost_full;
    assign wr_tdata     = s_tdata;
    assign wr_tvalid    = s_tvalid & ingress_open;
    assign wr_tlast     = s_tlast;
    assign s_tready     = wr_tready & ingress_open;
    assign wr_last_beat = wr_tvalid & wr_tready & wr_tlast;

endmodule

// File: verilog/frame_memory_mover.sv
module frame_memory_mover #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  ACLK,
    input  logic                  ARESET,
    input  logic                  clear,

    dm_cmd_if.mover               wr_cmd,
    input  logic [DATA_WIDTH-1:0] wr_tdata,
    input  logic                  wr_tvalid,
    input  logic                  wr_tlast,
    output logic                  wr_tready,

    dm_cmd_if.mover               rd_cmd,
    output logic [DATA_WIDTH-1:0] rd_tdata,
    output logic                  rd_tvalid,
    input  logic                  rd_tready
);

    localparam int MEM_WORDS = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0]                      mem [MEM_WORDS];

    frame_store_pkg::mover_state_e              wr_state;
    logic [ADDR_WIDTH-1:0]                      wr_addr;
    logic                                       wr_beat;
    logic                                       wr_cmplt;

    frame_store_pkg::mover_state_e              rd_state;
    logic [ADDR_WIDTH-1:0]                      rd_addr;
    logic [frame_store_pkg::SLOT_LEN_WIDTH-1:0] rd_left;
    logic                                       rd_beat;
    logic                                       rd_cmplt;

    assign wr_cmd.cmd_ready = (wr_state == frame_store_pkg::MOVER_IDLE);
    assign wr_tready        = (wr_state == frame_store_pkg::MOVER_WRITING);
    assign wr_beat          = wr_tvalid & wr_tready;
    assign wr_cmd.cmplt     = wr_cmplt;

    // write machine stores until tlast, the slot length only bounds the frame
    always_ff @(posedge ACLK) begin
        if (ARESET || clear) begin
            wr_state <= frame_store_pkg::MOVER_IDLE;
            wr_cmplt <= 1'b0;
        end else begin
            wr_cmplt <= wr_beat & wr_tlast;
            case (wr_state)
                frame_store_pkg::MOVER_IDLE: begin
                    if (wr_cmd.cmd_valid) begin
                        wr_state <= frame_store_pkg::MOVER_WRITING;
                    end
                end
                frame_store_pkg::MOVER_WRITING: begin
                    if (wr_beat && wr_tlast) begin
                        wr_state <= frame_store_pkg::MOVER_IDLE;
                    end
                end
                default: wr_state <= frame_store_pkg::MOVER_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_cmd.cmd_valid && wr_cmd.cmd_ready) begin
            wr_addr <= wr_cmd.cmd_addr;
        end else if (wr_beat) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_beat) begin
            mem[wr_addr] <= wr_tdata;
        end
    end

    assign rd_cmd.cmd_ready = (rd_state == frame_store_pkg::MOVER_IDLE);
    assign rd_tvalid        = (rd_state == frame_store_pkg::MOVER_READING);
    // read port is addressed from a register, so data is stable while stalled
    assign rd_tdata         = mem[rd_addr];
    assign rd_beat          = rd_tvalid & rd_tready;
    assign rd_cmd.cmplt     = rd_cmplt;

    always_ff @(posedge ACLK) begin
        if (ARESET || clear) begin
            rd_state <= frame_store_pkg::MOVER_IDLE;
            rd_cmplt <= 1'b0;
        end else begin
            rd_cmplt <= rd_beat && (rd_left == 1);
            case (rd_state)
                frame_store_pkg::MOVER_IDLE: begin
                    if (rd_cmd.cmd_valid) begin
                        rd_state <= frame_store_pkg::MOVER_READING;
                    end
                end
                frame_store_pkg::MOVER_READING: begin
                    if (rd_beat && (rd_left == 1)) begin
                        rd_state <= frame_store_pkg::MOVER_IDLE;
                    end
                end
                default: rd_state <= frame_store_pkg::MOVER_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (rd_cmd.cmd_valid && rd_cmd.cmd_ready) begin
            rd_addr <= rd_cmd.cmd_addr;
            rd_left <= rd_cmd.cmd_len;
        end else if (rd_beat) begin
            rd_addr <= rd_addr + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
    end

endmodule

// File: verilog/frame_egress.sv
module frame_egress #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    ACLK,
    input  logic                    ARESET,
    input  logic                    clear,

    input  logic [DATA_WIDTH-1:0]   rd_tdata,
    input  logic                    rd_tvalid,
    output logic                    rd_tready,

    output logic [DATA_WIDTH-1:0]   m_tdata,
    output logic                    m_tvalid,
    output logic                    m_tlast,
    output logic [DATA_WIDTH/8-1:0] m_tkeep,
    input  logic                    m_tready
);

    localparam int MW = frame_store_pkg::MARK_WIDTH;

    frame_store_pkg::egress_state_e state;
    logic [DATA_WIDTH-1:0]          out_data;
    logic                           out_valid;
    logic                           out_last;
    logic                           in_beat;
    logic                           is_header;
    logic                           is_footer;

    // take a new beat whenever the output register is free or draining
    assign rd_tready = ~out_valid | m_tready;
    assign in_beat   = rd_tvalid & rd_tready;
    assign is_header = (rd_tdata[DATA_WIDTH-1 -: MW] == frame_store_pkg::HEADER_MARK);
    assign is_footer = (rd_tdata[DATA_WIDTH-1 -: MW] == frame_store_pkg::FOOTER_MARK);

    always_ff @(posedge ACLK) begin
        if (ARESET || clear) begin
            state     <= frame_store_pkg::EGRESS_HUNT;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (in_beat) begin
            if (state == frame_store_pkg::EGRESS_PASS || is_header) begin
                out_valid <= 1'b1;
                out_last  <= (state == frame_store_pkg::EGRESS_PASS) && is_footer;
                state     <= (state == frame_store_pkg::EGRESS_PASS && is_footer) ?
                             frame_store_pkg::EGRESS_HUNT : frame_store_pkg::EGRESS_PASS;
            end else begin
                // filler between frames is dropped
                out_valid <= 1'b0;
            end
        end else if (m_tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (in_beat) begin
            out_data <= rd_tdata;
        end
    end

    assign m_tdata  = out_data;
    assign m_tvalid = out_valid;
    assign m_tlast  = out_last;
    // footer keeps only its upper half
    assign m_tkeep  = out_last ? {{(DATA_WIDTH/16){1'b1}}, {(DATA_WIDTH/16){1'b0}}}
                               : {(DATA_WIDTH/8){1'b1}};

endmodule

// File: verilog/frame_store_top.sv
module frame_store_top #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6
) (
    input  logic                                       ACLK,
    input  logic                                       ARESET,
    input  logic                                       set_config,
    input  logic [frame_store_pkg::SLOT_LEN_WIDTH-1:0] max_frame_beats,

    input  logic [DATA_WIDTH-1:0]                      s_tdata,
    input  logic                                       s_tvalid,
    input  logic                                       s_tlast,
    output logic                                       s_tready,

    output logic [DATA_WIDTH-1:0]                      m_tdata,
    output logic                                       m_tvalid,
    output logic                                       m_tlast,
    output logic [DATA_WIDTH/8-1:0]                    m_tkeep,
    input  logic                                       m_tready
);

    logic [DATA_WIDTH-1:0] wr_tdata;
    logic                  wr_tvalid;
    logic                  wr_tlast;
    logic                  wr_tready;

    logic [DATA_WIDTH-1:0] rd_tdata;
    logic                  rd_tvalid;
    logic                  rd_tready;

    dm_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) wr_cmd ();
    dm_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) rd_cmd ();

    frame_buffer_mmu #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) frame_buffer_mmu_inst (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .set_config     (set_config),
        .max_frame_beats(max_frame_beats),
        .s_tdata        (s_tdata),
        .s_tvalid       (s_tvalid),
        .s_tlast        (s_tlast),
        .s_tready       (s_tready),
        .wr_tdata       (wr_tdata),
        .wr_tvalid      (wr_tvalid),
        .wr_tlast       (wr_tlast),
        .wr_tready      (wr_tready),
        .wr_cmd         (wr_cmd.mmu),
        .rd_cmd         (rd_cmd.mmu)
    );

    // stands in for the external memory and its data mover
    frame_memory_mover #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) frame_memory_mover_inst (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .clear    (set_config),
        .wr_cmd   (wr_cmd.mover),
        .wr_tdata (wr_tdata),
        .wr_tvalid(wr_tvalid),
        .wr_tlast (wr_tlast),
        .wr_tready(wr_tready),
        .rd_cmd   (rd_cmd.mover),
        .rd_tdata (rd_tdata),
        .rd_tvalid(rd_tvalid),
        .rd_tready(rd_tready)
    );

    frame_egress #(
        .DATA_WIDTH(DATA_WIDTH)
    ) frame_egress_inst (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .clear    (set_config),
        .rd_tdata (rd_tdata),
        .rd_tvalid(rd_tvalid),
        .rd_tready(rd_tready),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tkeep  (m_tkeep),
        .m_tready (m_tready)
    );

endmodule

// File: test/frame_store_assert.sv
module frame_store_assert (
    input logic ACLK,
    input logic ARESET,
    input logic set_config,
    input logic full,
    input logic empty,
    input logic s_tready,
    input logic wr_cmd_valid,
    input logic wr_cmd_ready,
    input logic rd_cmd_valid,
    input logic rd_cmd_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // an offered command stays up until taken, unless a config clears it
    property cmd_held(logic valid, logic ready);
        @(posedge ACLK) disable iff (ARESET)
            valid && !ready && !set_config |=> valid;
    endproperty

    wr_cmd_held: assert property (cmd_held(wr_cmd_valid, wr_cmd_ready))
        else $error("write command valid dropped before it was accepted");

    rd_cmd_held: assert property (cmd_held(rd_cmd_valid, rd_cmd_ready))
        else $error("read command valid dropped before it was accepted");

    flags_exclusive: assert property (@(posedge ACLK) disable iff (ARESET) !(full && empty))
        else $error("ring reports full and empty at once");

    ingress_closed_when_full: assert property (
        @(posedge ACLK) disable iff (ARESET) full |-> !s_tready)
        else $error("s_tready high while the ring is full");

endmodule

bind frame_buffer_mmu frame_store_assert frame_store_assert_inst (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .set_config  (set_config),
    .full        (full),
    .empty       (empty),
    .s_tready    (s_tready),
    .wr_cmd_valid(wr_cmd_valid),
    .wr_cmd_ready(wr_cmd.cmd_ready),
    .rd_cmd_valid(rd_cmd_valid),
    .rd_cmd_ready(rd_cmd.cmd_ready)
);

// File: test/frame_store_tb.sv
module frame_store_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 6;
    localparam int KEEP_WIDTH   = DATA_WIDTH / 8;
    localparam int SLW          = frame_store_pkg::SLOT_LEN_WIDTH;
    // ingress counts as stalled after this many blocked cycles in a row
    localparam int STALL_CYCLES = 32;
    // stall mode gives up holding m_tready low after this many cycles
    localparam int HOLD_LIMIT   = 200;
    localparam int DRAIN_CYCLES = 40;
    localparam string TRACE_FILE = "test/frame_store_trace.txt";

    logic                  ACLK;
    logic                  ARESET;
    logic                  set_config;
    logic [SLW-1:0]        max_frame_beats;
    logic [DATA_WIDTH-1:0] s_tdata;
    logic                  s_tvalid;
    logic                  s_tlast;
    logic                  s_tready;
    logic [DATA_WIDTH-1:0] m_tdata;
    logic                  m_tvalid;
    logic                  m_tlast;
    logic [KEEP_WIDTH-1:0] m_tkeep;
    logic                  m_tready;

    // trace beats, flattened over all tests
    logic [DATA_WIDTH-1:0] beat_data [$];
    logic                  beat_last [$];
    logic [KEEP_WIDTH-1:0] beat_keep [$];
    // one step per C or T record, arg is the slot length or the ready mode
    byte                   step_kind [$];
    int                    step_arg [$];
    string                 step_name [$];
    int                    step_first [$];
    int                    step_count [$];

    // beats the DUT still owes in the running test
    logic [DATA_WIDTH-1:0] exp_data [$];
    logic                  exp_last [$];
    logic [KEEP_WIDTH-1:0] exp_keep [$];

    string       test_name = "reset";
    int          ready_mode = 0;
    logic        stall_seen = 1'b0;
    int          blocked_cycles = 0;
    int          hold_cycles = 0;
    int          out_index = 0;
    integer      seed = 32'h49c42365;
    logic [31:0] rand_word;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          step;
    int          mismatch_errors = 0;
    int          missing_errors = 0;
    int          extra_errors = 0;
    int          other_errors = 0;

    frame_store_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) frame_store_top_inst (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .set_config     (set_config),
        .max_frame_beats(max_frame_beats),
        .s_tdata        (s_tdata),
        .s_tvalid       (s_tvalid),
        .s_tlast        (s_tlast),
        .s_tready       (s_tready),
        .m_tdata        (m_tdata),
        .m_tvalid       (m_tvalid),
        .m_tlast        (m_tlast),
        .m_tkeep        (m_tkeep),
        .m_tready       (m_tready)
    );

    initial ACLK = 1'b0;
    always #50 ACLK = ~ACLK;

    task automatic read_trace();
        int                    fd;
        int                    code;
        logic [8*32-1:0]       tok;
        logic [8*200-1:0]      rest;
        int                    count;
        int                    arg;
        int                    mode;
        int                    repeats;
        logic [KEEP_WIDTH-1:0] keep_body;
        logic [KEEP_WIDTH-1:0] keep_foot;
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] frame_words [$];
        logic                  frame_ends [$];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open trace file %s", TRACE_FILE);
            other_errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "C") begin
                code = $fscanf(fd, "%d", arg);
                step_kind.push_back("C");
                step_arg.push_back(arg);
                step_name.push_back("config");
                step_first.push_back(0);
                step_count.push_back(0);
            end else if (tok == "T") begin
                code = $fscanf(fd, "%s %d %d %h %h", tok, mode, repeats, keep_body, keep_foot);
                step_kind.push_back("T");
                step_arg.push_back(mode);
                step_name.push_back(string'(tok));
                step_first.push_back(beat_data.size());
                step_count.push_back(0);
                frame_words.delete();
                frame_ends.delete();
            end else if (tok == "F") begin
                code = $fscanf(fd, "%d", count);
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", word);
                    frame_words.push_back(word);
                    frame_ends.push_back(i == count - 1);
                end
            end else if (tok == "E") begin
                // each repeat folds its index into bits 15:8 so copies stay distinct
                for (int r = 0; r < repeats; r++) begin
                    for (int i = 0; i < frame_words.size(); i++) begin
                        beat_data.push_back(frame_words[i] ^ (DATA_WIDTH'(r) << 8));
                        beat_last.push_back(frame_ends[i]);
                        beat_keep.push_back(frame_ends[i] ? keep_foot : keep_body);
                    end
                end
                step_count[step_count.size() - 1] =
                    beat_data.size() - step_first[step_first.size() - 1];
            end else begin
                $display("ERROR: unknown record %s in the trace file", string'(tok));
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic print_error_counts();
        $display("errors: %0d mismatch, %0d missing, %0d extra, %0d other",
                 mismatch_errors, missing_errors, extra_errors, other_errors);
    endtask

    task automatic apply_config(input int slot_len);
        set_config      <= 1'b1;
        max_frame_beats <= SLW'(slot_len);
        @(posedge ACLK);
        set_config      <= 1'b0;
        @(posedge ACLK);
    endtask

    // one beat per accepted handshake, s_tready sampled at the falling edge
    task automatic send_beats(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            s_tdata  <= beat_data[i];
            s_tvalid <= 1'b1;
            s_tlast  <= beat_last[i];
            @(negedge ACLK);
            while (!s_tready) begin
                @(negedge ACLK);
            end
            @(posedge ACLK);
        end
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
    endtask

    task automatic run_test(input int idx);
        int first;
        int count;
        first       = step_first[idx];
        count       = step_count[idx];
        test_name   = step_name[idx];
        out_index   = 0;
        hold_cycles = 0;
        ready_mode  <= step_arg[idx];
        stall_seen  <= 1'b0;
        for (int i = first; i < first + count; i++) begin
            exp_data.push_back(beat_data[i]);
            exp_last.push_back(beat_last[i]);
            exp_keep.push_back(beat_keep[i]);
        end
        send_beats(first, count);
        while (exp_data.size() != 0) begin
            @(posedge ACLK);
        end
        if (step_arg[idx] == 2 && !stall_seen) begin
            $display("ERROR: test %s: s_tready never fell while m_tready was held low",
                     test_name);
            other_errors++;
        end
        @(posedge ACLK);
    endtask

    task automatic check_beat();
        if (exp_data.size() == 0) begin
            $display("ERROR: test %s: extra output beat %h with no beat expected",
                     test_name, m_tdata);
            extra_errors++;
        end else begin
            if (m_tdata !== exp_data[0]) begin
                $display("MISMATCH test %s beat %0d tdata: expected %h, actual %h",
                         test_name, out_index, exp_data[0], m_tdata);
                mismatch_errors++;
            end
            if (m_tlast !== exp_last[0]) begin
                $display("MISMATCH test %s beat %0d tlast: expected %b, actual %b",
                         test_name, out_index, exp_last[0], m_tlast);
                mismatch_errors++;
            end
            if (m_tkeep !== exp_keep[0]) begin
                $display("MISMATCH test %s beat %0d tkeep: expected %h, actual %h",
                         test_name, out_index, exp_keep[0], m_tkeep);
                mismatch_errors++;
            end
            void'(exp_data.pop_front());
            void'(exp_last.pop_front());
            void'(exp_keep.pop_front());
            out_index++;
        end
    endtask

    // m_tready pattern per test
    // stall mode opens once ingress stalls or the hold limit runs out
    always @(posedge ACLK) begin
        rand_word = $random(seed);
        if (ARESET) begin
            m_tready <= 1'b0;
        end else begin
            case (ready_mode)
                0:       m_tready <= 1'b1;
                1:       m_tready <= rand_word[0];
                default: m_tready <= stall_seen || (hold_cycles >= HOLD_LIMIT);
            endcase
        end
    end

    // output handshakes sampled mid-cycle, where valid and ready are settled
    always @(negedge ACLK) begin
        if (!ARESET) begin
            if (ready_mode == 2 && s_tvalid && !s_tready) begin
                blocked_cycles++;
            end else begin
                blocked_cycles = 0;
            end
            if (blocked_cycles >= STALL_CYCLES) begin
                stall_seen = 1'b1;
            end
            if (ready_mode == 2) begin
                hold_cycles++;
            end
            if (m_tvalid && m_tready) begin
                check_beat();
            end
        end
    end

    always @(posedge ACLK) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("ERROR: timeout after %0d cycles in test %s, %0d expected beats missing",
                     cycle_count, test_name, exp_data.size());
            missing_errors += exp_data.size();
            print_error_counts();
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        ARESET          = 1'b1;
        set_config      = 1'b0;
        max_frame_beats = '0;
        s_tdata         = '0;
        s_tvalid        = 1'b0;
        s_tlast         = 1'b0;
        m_tready        = 1'b0;
        read_trace();
        cycle_limit = 20 * beat_data.size();
        repeat (4) @(posedge ACLK);
        ARESET <= 1'b0;
        @(posedge ACLK);
        for (step = 0; step < step_kind.size(); step++) begin
            if (step_kind[step] == "C") begin
                apply_config(step_arg[step]);
            end else begin
                run_test(step);
            end
        end
        // late beats after the last test show up as extra
        test_name = "drain";
        repeat (DRAIN_CYCLES) @(posedge ACLK);
        print_error_counts();
        if (mismatch_errors + missing_errors + extra_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/frame_store_pkg.sv
verilog/dm_cmd_if.sv
verilog/frame_buffer_mmu.sv
verilog/frame_memory_mover.sv
verilog/frame_egress.sv
verilog/frame_store_top.sv
test/frame_store_assert.sv
test/frame_store_tb.sv

// File: test/frame_store_trace.txt
# records: C slot_len | T name ready_mode repeat keep_body keep_footer | F n beats | E ends test
# ready_mode 0 high, 1 random, 2 low until ingress stalls; repeat r xors r into bits 15:8
C 16
T single_frame 0 1 f c
F 5 aa000010 01234567 0789abcd 0fedcba9 55000014
E
T in_order 0 1 f c
F 3 aa000020 10000021 55000022
F 6 aa000030 11112222 13334444 15556666 17778888 55000035
F 4 aa000040 19990000 1aaa0001 55000043
E
T random_ready 1 2 f c
F 7 aa000050 2000f051 2100e052 2200d053 2300c054 2400b055 55000056
F 4 aa000060 25000061 26000062 55000063
E
T pointer_wrap 0 5 f c
F 2 aa000070 55000071
F 9 aa000080 30000081 31000082 32000083 33000084 34000085 35000086 36000087 55000088
E
T ingress_stall 2 2 f c
F 6 aa000090 40000091 41000092 42000093 43000094 55000095
F 3 aa0000a0 44000000 550000a2
F 5 aa0000b0 45000001 46000002 47000003 550000b4
E
C 8
T new_slot_len 0 2 f c
F 8 aa0000c0 50000001 51000002 52000003 53000004 54000005 56000006 550000c7
F 5 aa0000d0 57000001 58000002 59000003 550000d4
E
